// ==== tests/arb_golden.txt ====
# test rd_vld rd_ram rd_tag wr_vld wr_ram wr_dir wr_tag gnt_rdy | rd_rdy wr_rdy gnt_vld op ram tag
# all hex; packed fields put requester 3 or port 1 in the high digits
1 0 0000 13121110 0 0000 0000 23222120 3 0 0 0 0 00 0000
1 0 0000 13121110 0 0000 0000 23222120 3 0 0 0 0 00 0000
2 7 0721 13121110 0 0000 0000 23222120 3 3 0 3 0 21 1110
2 4 0721 13121110 0 0000 0000 23222120 3 4 0 1 0 07 0012
2 0 0000 13121110 0 0000 0000 23222120 3 0 0 0 0 00 0000
3 0 0000 13121110 1 0000 0000 23222120 3 0 1 1 1 00 0020
3 0 0000 13121110 0 0000 0000 23222120 3 0 0 0 0 00 0000
3 3 0034 13121110 0 0000 0000 23222120 3 2 0 1 0 03 0011
3 1 0034 13121110 0 0000 0000 23222120 3 1 0 1 0 04 0010
3 0 0000 13121110 0 0000 0000 23222120 3 0 0 0 0 00 0000
3 0 0000 13121110 0 0000 0000 23222120 3 0 0 0 0 00 0000
3 0 0000 13121110 0 0000 0000 23222120 3 0 0 0 0 00 0000
3 0 0000 13121110 0 0000 0000 23222120 3 0 0 0 0 00 0000
3 0 0000 13121110 0 0000 0000 23222120 3 0 0 0 0 00 0000
3 3 0020 13121110 0 0000 0000 23222120 3 2 0 1 0 02 0011
3 1 0020 13121110 0 0000 0000 23222120 3 1 0 1 0 00 0010
4 0 0000 13121110 2 0010 0030 23222120 3 0 2 1 1 01 0021
4 0 0000 13121110 0 0000 0000 23222120 3 0 0 0 0 00 0000
4 0 0000 13121110 0 0000 0000 23222120 3 0 0 0 0 00 0000
4 0 0000 13121110 0 0000 0000 23222120 3 0 0 0 0 00 0000
4 0 0000 13121110 0 0000 0000 23222120 3 0 0 0 0 00 0000
4 0 0000 13121110 4 0300 0100 23222120 3 0 0 0 0 00 0000
4 0 0000 13121110 4 0300 0100 23222120 3 0 4 1 1 03 0022
5 0 0000 13121110 1 0004 0000 23222120 2 0 0 1 1 04 0020
5 0 0000 13121110 1 0004 0000 23222120 2 0 0 1 1 04 0020
5 1 0002 13121110 1 0004 0000 23222120 1 1 0 3 2 42 2010
5 0 0000 13121110 1 0004 0000 23222120 3 0 1 1 1 04 0020
5 0 0000 13121110 0 0000 0000 23222120 3 0 0 0 0 00 0000
5 1 0002 13121110 0 0000 0000 23222120 3 0 0 0 0 00 0000
5 1 0002 13121110 0 0000 0000 23222120 3 1 0 1 0 02 0010

// ==== list.f ====
+incdir+include
source/vc_arb_pkg.sv
source/read_admit.sv
source/write_admit.sv
source/dual_grant_arb.sv
source/slot_timers.sv
source/ram_port_arb_top.sv
tests/ram_port_arb_tb.sv

// ==== include/arb_checks.svh ====
`ifndef ARB_CHECKS_SVH
`define ARB_CHECKS_SVH

int unsigned pass_cnt = 0;
int unsigned fail_cnt = 0;

// shared tally for all typed compares
task automatic tally(input bit ok, input string name, input string got, input string exp);
    if (ok) begin
        pass_cnt++;
    end else begin
        fail_cnt++;
        $display("FAILED %s: got 0x%s, expected 0x%s at %0t ns", name, got, exp, $time);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    tally(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic check_op(input string name, input vc_arb_pkg::opcode_e got,
                        input vc_arb_pkg::opcode_e exp);
    tally(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic check_ram(input string name, input vc_arb_pkg::ram_id_t got,
                         input vc_arb_pkg::ram_id_t exp);
    tally(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic check_tag(input string name, input vc_arb_pkg::tag_t got,
                         input vc_arb_pkg::tag_t exp);
    tally(got === exp, name, $sformatf("%02h", got), $sformatf("%02h", exp));
endtask

`endif

// ==== tests/ram_port_arb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_port_arb_tb;

    import vc_arb_pkg::*;

    localparam int RD_NUM        = 4;
    localparam int WR_NUM        = 4;
    localparam int RESET_CYCLES  = 8;
    localparam int MARGIN_CYCLES = 20;

    logic                  clk;
    logic                  rst_n;
    logic [RD_NUM-1:0]     rd_vld;
    ram_id_t               rd_ram  [RD_NUM];
    tag_t                  rd_tag  [RD_NUM];
    logic [RD_NUM-1:0]     rd_rdy;
    logic [WR_NUM-1:0]     wr_vld;
    ram_id_t               wr_ram  [WR_NUM];
    direction_e            wr_dir  [WR_NUM];
    tag_t                  wr_tag  [WR_NUM];
    logic [WR_NUM-1:0]     wr_rdy;
    logic [NUM_GRANTS-1:0] gnt_vld;
    opcode_e               gnt_op  [NUM_GRANTS];
    ram_id_t               gnt_ram [NUM_GRANTS];
    tag_t                  gnt_tag [NUM_GRANTS];
    logic [NUM_GRANTS-1:0] gnt_rdy;

    logic [RD_NUM-1:0]     exp_rd_rdy;
    logic [WR_NUM-1:0]     exp_wr_rdy;
    logic [NUM_GRANTS-1:0] exp_gnt_vld;
    logic [NUM_GRANTS-1:0] exp_op;
    logic [7:0]            exp_ram;   // one hex digit per port
    logic [15:0]           exp_tag;

    string       vec_q [$];
    int          cycle_cnt    = 0;
    int          cycle_limit  = 1000;
    int          cur_test     = 1;
    int unsigned test_base    = 0;   // fail_cnt when this test began
    int          tests_passed = 0;
    int          tests_failed = 0;
    bit          loaded;

    `include "arb_checks.svh"

    ram_port_arb_top ram_port_arb_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_vld  (rd_vld),
        .rd_ram  (rd_ram),
        .rd_tag  (rd_tag),
        .rd_rdy  (rd_rdy),
        .wr_vld  (wr_vld),
        .wr_ram  (wr_ram),
        .wr_dir  (wr_dir),
        .wr_tag  (wr_tag),
        .wr_rdy  (wr_rdy),
        .gnt_vld (gnt_vld),
        .gnt_op  (gnt_op),
        .gnt_ram (gnt_ram),
        .gnt_tag (gnt_tag),
        .gnt_rdy (gnt_rdy)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("run stopped after %0d cycles without reaching the end", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic load_vectors(output bit ok);
        int    fd;
        string line;
        ok = 1'b0;
        fd = $fopen("tests/arb_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/arb_golden.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.substr(0, 0) != "#") begin   // skip column notes
                    vec_q.push_back(line);
                end
            end
            $fclose(fd);
            ok = (vec_q.size() > 0);
            if (!ok) begin
                $display("golden file holds no vectors");
            end
        end
    endtask

    task automatic drive_idle();
        rd_vld  = '0;
        wr_vld  = '0;
        gnt_rdy = '1;
        for (int i = 0; i < RD_NUM; i++) begin
            rd_ram[i] = '0;
            rd_tag[i] = '0;
        end
        for (int j = 0; j < WR_NUM; j++) begin
            wr_ram[j] = '0;
            wr_dir[j] = dir_west;
            wr_tag[j] = '0;
        end
    endtask

    task automatic close_test();
        if (fail_cnt == test_base) begin
            tests_passed++;
            $display("test %0d passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d mismatches", cur_test, fail_cnt - test_base);
        end
        test_base = fail_cnt;
    endtask

    task automatic apply_vector(input string line, output bit ok);
        int          tnum;
        int          n;
        logic [3:0]  v_rd_vld;
        logic [15:0] v_rd_ram;
        logic [31:0] v_rd_tag;
        logic [3:0]  v_wr_vld;
        logic [15:0] v_wr_ram;
        logic [15:0] v_wr_dir;
        logic [31:0] v_wr_tag;
        logic [1:0]  v_gnt_rdy;
        n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    tnum, v_rd_vld, v_rd_ram, v_rd_tag, v_wr_vld, v_wr_ram, v_wr_dir,
                    v_wr_tag, v_gnt_rdy, exp_rd_rdy, exp_wr_rdy, exp_gnt_vld, exp_op,
                    exp_ram, exp_tag);
        ok = (n == 15);
        if (!ok) begin
            fail_cnt++;
            $display("golden line has %0d of 15 fields and was skipped: %s", n, line);
            drive_idle();
        end else begin
            if (tnum != cur_test) begin
                close_test();
                cur_test = tnum;
            end
            rd_vld  = v_rd_vld;
            wr_vld  = v_wr_vld;
            gnt_rdy = v_gnt_rdy;
            for (int i = 0; i < RD_NUM; i++) begin
                rd_ram[i] = ram_id_t'(v_rd_ram[4*i +: 3]);
                rd_tag[i] = v_rd_tag[8*i +: 8];
            end
            for (int j = 0; j < WR_NUM; j++) begin
                wr_ram[j] = ram_id_t'(v_wr_ram[4*j +: 3]);
                wr_dir[j] = direction_e'(v_wr_dir[4*j +: 2]);
                wr_tag[j] = v_wr_tag[8*j +: 8];
            end
        end
    endtask

    task automatic check_outputs();
        for (int i = 0; i < RD_NUM; i++) begin
            check_bit($sformatf("rd_rdy[%0d]", i), rd_rdy[i], exp_rd_rdy[i]);
        end
        for (int j = 0; j < WR_NUM; j++) begin
            check_bit($sformatf("wr_rdy[%0d]", j), wr_rdy[j], exp_wr_rdy[j]);
        end
        for (int k = 0; k < NUM_GRANTS; k++) begin
            check_bit($sformatf("gnt_vld[%0d]", k), gnt_vld[k], exp_gnt_vld[k]);
            if (exp_gnt_vld[k]) begin   // idle port fields are don't care
                check_op($sformatf("gnt_op[%0d]", k), gnt_op[k], opcode_e'(exp_op[k]));
                check_ram($sformatf("gnt_ram[%0d]", k), gnt_ram[k],
                          ram_id_t'(exp_ram[4*k +: 3]));
                check_tag($sformatf("gnt_tag[%0d]", k), gnt_tag[k], exp_tag[8*k +: 8]);
            end
        end
    endtask

    // nothing requested, so nothing may be granted
    task automatic check_quiet();
        exp_rd_rdy  = '0;
        exp_wr_rdy  = '0;
        exp_gnt_vld = '0;
        check_outputs();
    endtask

    initial begin
        bit line_ok;
        rst_n = 1'b0;
        drive_idle();
        load_vectors(loaded);
        if (!loaded) begin
            $display("Test failures found");
            $finish;
        end else begin
            cycle_limit = vec_q.size() + RESET_CYCLES + MARGIN_CYCLES;
            repeat (RESET_CYCLES) begin
                @(posedge clk);
                #1;
                drive_idle();
                #2;
                check_quiet();
            end
            foreach (vec_q[n]) begin
                @(posedge clk);
                #1;
                rst_n = 1'b1;
                apply_vector(vec_q[n], line_ok);
                #2;   // sample just before the next edge
                if (line_ok) begin
                    check_outputs();
                end
            end
            close_test();
            $display("tests passed %0d, tests failed %0d, checks passed %0d, checks failed %0d",
                     tests_passed, tests_failed, pass_cnt, fail_cnt);
            if (tests_failed == 0 && fail_cnt == 0) begin
                $display("All tests passed!");
            end else begin
                $display("Test failures found");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== source/ram_port_arb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_port_arb_top #(
    parameter int RD_NUM = 4,
    parameter int WR_NUM = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [RD_NUM-1:0]                 rd_vld,
    input  vc_arb_pkg::ram_id_t               rd_ram  [RD_NUM],
    input  vc_arb_pkg::tag_t                  rd_tag  [RD_NUM],
    output logic [RD_NUM-1:0]                 rd_rdy,
    input  logic [WR_NUM-1:0]                 wr_vld,
    input  vc_arb_pkg::ram_id_t               wr_ram  [WR_NUM],
    input  vc_arb_pkg::direction_e            wr_dir  [WR_NUM],
    input  vc_arb_pkg::tag_t                  wr_tag  [WR_NUM],
    output logic [WR_NUM-1:0]                 wr_rdy,
    output logic [vc_arb_pkg::NUM_GRANTS-1:0] gnt_vld,
    output vc_arb_pkg::opcode_e               gnt_op  [vc_arb_pkg::NUM_GRANTS],
    output vc_arb_pkg::ram_id_t               gnt_ram [vc_arb_pkg::NUM_GRANTS],
    output vc_arb_pkg::tag_t                  gnt_tag [vc_arb_pkg::NUM_GRANTS],
    input  logic [vc_arb_pkg::NUM_GRANTS-1:0] gnt_rdy
);

    import vc_arb_pkg::*;

    logic [RD_NUM-1:0]       rd_admit;
    logic [WR_NUM-1:0]       wr_admit;
    logic [RAM_TIMER_W-1:0]  ram_busy   [NUM_RAMS];
    logic [CHAN_TIMER_W-1:0] chan_busy  [NUM_CHANNELS];
    direction_e              gnt_wr_dir [NUM_GRANTS];
    logic [NUM_GRANTS-1:0]   gnt_fire;

    read_admit #(
        .RD_NUM    (RD_NUM)
    ) read_admit_i (
        .rd_vld    (rd_vld),
        .rd_ram    (rd_ram),
        .ram_busy  (ram_busy),
        .chan_busy (chan_busy),
        .rd_admit  (rd_admit)
    );

    write_admit #(
        .WR_NUM    (WR_NUM)
    ) write_admit_i (
        .wr_vld    (wr_vld),
        .wr_ram    (wr_ram),
        .wr_dir    (wr_dir),
        .ram_busy  (ram_busy),
        .chan_busy (chan_busy),
        .wr_admit  (wr_admit)
    );

    dual_grant_arb #(
        .RD_NUM     (RD_NUM),
        .WR_NUM     (WR_NUM)
    ) dual_grant_arb_i (
        .rd_admit   (rd_admit),
        .wr_admit   (wr_admit),
        .rd_ram     (rd_ram),
        .rd_tag     (rd_tag),
        .wr_ram     (wr_ram),
        .wr_dir     (wr_dir),
        .wr_tag     (wr_tag),
        .gnt_rdy    (gnt_rdy),
        .rd_rdy     (rd_rdy),
        .wr_rdy     (wr_rdy),
        .gnt_vld    (gnt_vld),
        .gnt_op     (gnt_op),
        .gnt_ram    (gnt_ram),
        .gnt_tag    (gnt_tag),
        .gnt_wr_dir (gnt_wr_dir),
        .gnt_fire   (gnt_fire)
    );

    // timers feed back into both admission checks
    slot_timers slot_timers_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .gnt_fire   (gnt_fire),
        .gnt_op     (gnt_op),
        .gnt_ram    (gnt_ram),
        .gnt_wr_dir (gnt_wr_dir),
        .ram_busy   (ram_busy),
        .chan_busy  (chan_busy)
    );

endmodule

`default_nettype wire

// ==== source/slot_timers.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_timers (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [vc_arb_pkg::NUM_GRANTS-1:0]   gnt_fire,
    input  vc_arb_pkg::opcode_e                 gnt_op     [vc_arb_pkg::NUM_GRANTS],
    input  vc_arb_pkg::ram_id_t                 gnt_ram    [vc_arb_pkg::NUM_GRANTS],
    input  vc_arb_pkg::direction_e              gnt_wr_dir [vc_arb_pkg::NUM_GRANTS],
    output logic [vc_arb_pkg::RAM_TIMER_W-1:0]  ram_busy   [vc_arb_pkg::NUM_RAMS],
    output logic [vc_arb_pkg::CHAN_TIMER_W-1:0] chan_busy  [vc_arb_pkg::NUM_CHANNELS]
);

    import vc_arb_pkg::*;

    logic [NUM_GRANTS-1:0]   wr_fire;
    logic [RAM_TIMER_W-1:0]  ram_set  [NUM_GRANTS];
    logic [CHAN_TIMER_W-1:0] chan_set [NUM_GRANTS];

    // only accepted writes reserve anything
    for (genvar k = 0; k < NUM_GRANTS; k++) begin : g_fire
        assign wr_fire[k] = gnt_fire[k] & (gnt_op[k] == op_write);
    end

    always_comb begin
        for (int k = 0; k < NUM_GRANTS; k++) begin
            ram_set[k]  = '0;
            chan_set[k] = '0;
            if (wr_fire[k]) begin
                ram_set[k][write_ram_slot(gnt_wr_dir[k], gnt_ram[k][2:1])] = 1'b1;
                chan_set[k][write_chan_slot(gnt_wr_dir[k])]                = 1'b1;
            end
        end
    end

    for (genvar r = 0; r < NUM_RAMS; r++) begin : g_ram
        logic [RAM_TIMER_W-1:0] ram_or;

        always_comb begin
            ram_or = '0;
            for (int k = 0; k < NUM_GRANTS; k++) begin
                if (gnt_ram[k] == ram_id_t'(r)) begin
                    ram_or = ram_or | ram_set[k];
                end
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                ram_busy[r] <= '0;
            end else begin
                ram_busy[r] <= (ram_busy[r] >> 1) | ram_or;   // one slot closer per clock
            end
        end
    end

    for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
        logic [CHAN_TIMER_W-1:0] chan_or;

        always_comb begin
            chan_or = '0;
            for (int k = 0; k < NUM_GRANTS; k++) begin
                if (gnt_ram[k][0] == 1'(c)) begin   // channel is the RAM id lsb
                    chan_or = chan_or | chan_set[k];
                end
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                chan_busy[c] <= '0;
            end else begin
                chan_busy[c] <= (chan_busy[c] >> 1) | chan_or;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/dual_grant_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_grant_arb #(
    parameter int RD_NUM = 4,
    parameter int WR_NUM = 4
) (
    input  logic [RD_NUM-1:0]                 rd_admit,
    input  logic [WR_NUM-1:0]                 wr_admit,
    input  vc_arb_pkg::ram_id_t               rd_ram     [RD_NUM],
    input  vc_arb_pkg::tag_t                  rd_tag     [RD_NUM],
    input  vc_arb_pkg::ram_id_t               wr_ram     [WR_NUM],
    input  vc_arb_pkg::direction_e            wr_dir     [WR_NUM],
    input  vc_arb_pkg::tag_t                  wr_tag     [WR_NUM],
    input  logic [vc_arb_pkg::NUM_GRANTS-1:0] gnt_rdy,
    output logic [RD_NUM-1:0]                 rd_rdy,
    output logic [WR_NUM-1:0]                 wr_rdy,
    output logic [vc_arb_pkg::NUM_GRANTS-1:0] gnt_vld,
    output vc_arb_pkg::opcode_e               gnt_op     [vc_arb_pkg::NUM_GRANTS],
    output vc_arb_pkg::ram_id_t               gnt_ram    [vc_arb_pkg::NUM_GRANTS],
    output vc_arb_pkg::tag_t                  gnt_tag    [vc_arb_pkg::NUM_GRANTS],
    output vc_arb_pkg::direction_e            gnt_wr_dir [vc_arb_pkg::NUM_GRANTS],
    output logic [vc_arb_pkg::NUM_GRANTS-1:0] gnt_fire
);

    import vc_arb_pkg::*;

    localparam int N = RD_NUM + WR_NUM;

    logic [N-1:0] req;
    logic [N-1:0] req_left [NUM_GRANTS];   // requests not yet taken by a lower port
    logic [N-1:0] gnt_oh   [NUM_GRANTS];
    logic [N-1:0] req_rdy;

    assign req = {wr_admit, rd_admit};   // reads sit in the low bits

    assign req_left[0] = req;

    for (genvar k = 0; k < NUM_GRANTS; k++) begin : g_port
        // lowest remaining request wins this port
        assign gnt_oh[k]  = req_left[k] & (~req_left[k] + 1'b1);
        assign gnt_vld[k] = |gnt_oh[k];

        if (k + 1 < NUM_GRANTS) begin : g_next
            assign req_left[k+1] = req_left[k] & ~gnt_oh[k];
        end
    end

    assign gnt_fire = gnt_vld & gnt_rdy;

    // route the fields of the winner onto each port
    always_comb begin
        for (int k = 0; k < NUM_GRANTS; k++) begin
            gnt_op[k]     = op_read;
            gnt_ram[k]    = '0;
            gnt_tag[k]    = '0;
            gnt_wr_dir[k] = dir_west;
            for (int i = 0; i < RD_NUM; i++) begin
                if (gnt_oh[k][i]) begin
                    gnt_ram[k] = rd_ram[i];
                    gnt_tag[k] = rd_tag[i];
                end
            end
            for (int j = 0; j < WR_NUM; j++) begin
                if (gnt_oh[k][RD_NUM+j]) begin
                    gnt_op[k]     = op_write;
                    gnt_ram[k]    = wr_ram[j];
                    gnt_tag[k]    = wr_tag[j];
                    gnt_wr_dir[k] = wr_dir[j];
                end
            end
        end
    end

    // a requester only sees rdy when its port is accepted by the SRAM
    always_comb begin
        req_rdy = '0;
        for (int k = 0; k < NUM_GRANTS; k++) begin
            if (gnt_rdy[k]) begin
                req_rdy = req_rdy | gnt_oh[k];
            end
        end
    end

    assign rd_rdy = req_rdy[RD_NUM-1:0];
    assign wr_rdy = req_rdy[N-1:RD_NUM];

endmodule

`default_nettype wire

// ==== source/write_admit.sv ====
`timescale 1ns/1ps
`default_nettype none

module write_admit #(
    parameter int WR_NUM = 4
) (
    input  logic [WR_NUM-1:0]                   wr_vld,
    input  vc_arb_pkg::ram_id_t                 wr_ram    [WR_NUM],
    input  vc_arb_pkg::direction_e              wr_dir    [WR_NUM],
    input  logic [vc_arb_pkg::RAM_TIMER_W-1:0]  ram_busy  [vc_arb_pkg::NUM_RAMS],
    input  logic [vc_arb_pkg::CHAN_TIMER_W-1:0] chan_busy [vc_arb_pkg::NUM_CHANNELS],
    output logic [WR_NUM-1:0]                   wr_admit
);

    import vc_arb_pkg::*;

    logic [WR_NUM-1:0] chan_free;
    logic [WR_NUM-1:0] ram_free;

    // each direction owns its own slot offset, so two writes from
    // different directions never land on the same timer bit
    for (genvar j = 0; j < WR_NUM; j++) begin : g_wr
        block_t     blk;
        logic       chan;
        direction_e dir;
        int         chan_slot;
        int         ram_slot;

        assign blk  = wr_ram[j][2:1];
        assign chan = wr_ram[j][0];
        assign dir  = wr_dir[j];

        assign chan_slot = write_chan_slot(dir);       // command on channel
        assign ram_slot  = write_ram_slot(dir, blk);   // data into RAM

        assign chan_free[j] = ~chan_busy[chan][chan_slot];
        assign ram_free[j]  = ~ram_busy[wr_ram[j]][ram_slot];

        assign wr_admit[j] = wr_vld[j] & chan_free[j] & ram_free[j];
    end

endmodule

`default_nettype wire

// ==== source/read_admit.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_admit #(
    parameter int RD_NUM = 4
) (
    input  logic [RD_NUM-1:0]                   rd_vld,
    input  vc_arb_pkg::ram_id_t                 rd_ram    [RD_NUM],
    input  logic [vc_arb_pkg::RAM_TIMER_W-1:0]  ram_busy  [vc_arb_pkg::NUM_RAMS],
    input  logic [vc_arb_pkg::CHAN_TIMER_W-1:0] chan_busy [vc_arb_pkg::NUM_CHANNELS],
    output logic [RD_NUM-1:0]                   rd_admit
);

    import vc_arb_pkg::*;

    logic [RD_NUM-1:0] chan_free;
    logic [RD_NUM-1:0] ram_free;

    for (genvar i = 0; i < RD_NUM; i++) begin : g_rd
        block_t blk;
        logic   chan;
        int     ram_slot;

        assign blk  = rd_ram[i][2:1];
        assign chan = rd_ram[i][0];

        // farther blocks take longer to reach
        assign ram_slot = read_ram_slot(blk);

        // read drives the channel next cycle, bit 0 is that cycle
        assign chan_free[i] = ~chan_busy[chan][0];

        // no write data landing in this RAM when the read gets there
        assign ram_free[i] = ~ram_busy[rd_ram[i]][ram_slot];

        assign rd_admit[i] = rd_vld[i] & chan_free[i] & ram_free[i];
    end

endmodule

`default_nettype wire

// ==== source/vc_arb_pkg.sv ====
`default_nettype none

package vc_arb_pkg;

    localparam int NUM_RAMS     = 8;
    localparam int NUM_CHANNELS = 2;
    localparam int NUM_GRANTS   = 2;

    localparam int RAM_TIMER_W  = 20;
    localparam int CHAN_TIMER_W = 10;

    typedef logic [2:0] ram_id_t;   // {block, channel}
    typedef logic [1:0] block_t;
    typedef logic [7:0] tag_t;

    typedef enum logic [1:0] {
        dir_west,
        dir_east,
        dir_south,
        dir_north
    } direction_e;

    typedef enum logic {
        op_read,
        op_write
    } opcode_e;

    // cycles until a write command reaches the channel
    localparam int WR_CMD_DELAY_WEST  = 1;
    localparam int WR_CMD_DELAY_EAST  = 3;
    localparam int WR_CMD_DELAY_SOUTH = 5;
    localparam int WR_CMD_DELAY_NORTH = 7;

    localparam int RD_BLOCK_DELAY [0:3] = '{1, 2, 3, 4};
    localparam int WR_BLOCK_DELAY [0:3] = '{8, 7, 6, 5};   // far blocks see data sooner

    function automatic int read_ram_slot(block_t blk);
        return RD_BLOCK_DELAY[blk];
    endfunction

    function automatic int write_chan_slot(direction_e dir);
        case (dir)
            dir_west:  return WR_CMD_DELAY_WEST;
            dir_east:  return WR_CMD_DELAY_EAST;
            dir_south: return WR_CMD_DELAY_SOUTH;
            dir_north: return WR_CMD_DELAY_NORTH;
            default:   return 0;
        endcase
    endfunction

    // data lands in the RAM after the command delay plus the block delay
    function automatic int write_ram_slot(direction_e dir, block_t blk);
        return write_chan_slot(dir) + WR_BLOCK_DELAY[blk];
    endfunction

endpackage

`default_nettype wire
